// ==== verilog.f ====
pcs_rx_pkg.sv
am_lock_lane_rx.sv
deskew_ctrl_rx.sv
deskew_lane_rx.sv
lane_reorder_rx.sv
pcs_rx_deskew.sv
tb_clock_gen.sv
pcs_rx_deskew_tb.sv

// ==== pcs_rx_deskew_tb.sv ====
// Testbench for the multi-lane PCS receive deskew
// skewed and swapped lane streams with markers, lock, alignment,
// per-cycle output compare against a reference, then loss and relock
`default_nettype none

module pcs_rx_deskew_tb;

localparam int NUM_LANES        = 4;
localparam int AM_PERIOD        = 64;
localparam int MAX_SKEW_BLOCK_N = 8;
localparam int DRV_DLY          = 10;
localparam int LAT              = 3; // lock, deskew and reorder registers
localparam int RELOCK_BASE      = 8; // common extra delay after the loss
localparam int DLY_N            = RELOCK_BASE + MAX_SKEW_BLOCK_N;
localparam int CORRUPT_LANE     = 2;
localparam int TIMEOUT_CYC      = 12 * AM_PERIOD + 200;
localparam logic [15:0] SEED    = 16'd62858;

logic                           clk;
logic                           nreset;
logic [NUM_LANES-1:0][65:0]     lane_data;
logic [NUM_LANES-1:0][65:0]     data_out;
logic                           aligned;
logic [NUM_LANES-1:0]           lane_lock;

logic [15:0] lfsr_q;
int          perm [NUM_LANES];  // logical lane to physical lane
int          delay [NUM_LANES]; // per logical lane, in blocks
int          max_delay;
logic [65:0] dline [NUM_LANES][DLY_N];
longint      drv_idx = -1;      // stream index of the undelayed tap
bit          corrupt_pending = 0;
bit          cmp_en = 0;
bit          have_prev = 0;
longint      prev_seq;
int          deskew_err;
int          reorder_err;
int          am_rows;
int          test_pass = 0;
int          test_fail = 0;
int          cycle_cnt = 0;

tb_clock_gen #(
	.PERIOD(100),
	.RESET_CYC(10),
	.DRV_DLY(DRV_DLY)
) clk_gen_i (
	.clk_o    (clk),
	.nreset_o (nreset)
);

pcs_rx_deskew #(
	.NUM_LANES(NUM_LANES),
	.AM_PERIOD(AM_PERIOD),
	.MAX_SKEW_BLOCK_N(MAX_SKEW_BLOCK_N)
) dut_i (
	.clk         (clk),
	.nreset      (nreset),
	.lane_data_i (lane_data),
	.data_o      (data_out),
	.aligned_o   (aligned),
	.lane_lock_o (lane_lock)
);

// right-shift Galois form, taps 16 14 13 11
function automatic logic [15:0] lfsr_next(input logic [15:0] s);
	return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

// uniform value in 0..limit, one LFSR step per bit
task automatic draw_upto(input int limit, output int val);
	int w;
	w = 1;
	while ((1 << w) <= limit)
		w++;
	val = limit + 1;
	while (val > limit) begin
		val = 0;
		for (int b = 0; b < w; b++) begin
			val = (val << 1) | lfsr_q[0];
			lfsr_q = lfsr_next(lfsr_q);
		end
	end
endtask

function automatic logic [23:0] marker_bytes(input int lane);
	case (lane)
		0:       return 24'h907647;
		1:       return 24'hF0C4E6;
		2:       return 24'hC5659B;
		default: return 24'hA2793D;
	endcase
endfunction

function automatic logic [65:0] ref_am(input int lane);
	logic [23:0] m;
	m = marker_bytes(lane);
	return {2'b10, m, 8'h3C, ~m, 8'hC3}; // bip bytes are don't-care filler
endfunction

function automatic logic [65:0] ref_data(input int lane, input longint seq);
	return {2'b01, 8'hD5, 6'd0, lane[1:0], seq[47:0]};
endfunction

// stream block of a logical lane, markers at multiples of the period
function automatic logic [65:0] block_at(input int lane, input longint idx);
	if (idx % AM_PERIOD == 0)
		return ref_am(lane);
	return ref_data(lane, idx - idx / AM_PERIOD - 1);
endfunction

task automatic pick_perm();
	int j;
	int t;
	for (int l = 0; l < NUM_LANES; l++)
		perm[l] = l;
	for (int i = NUM_LANES - 1; i > 0; i--) begin
		draw_upto(i, j);
		t = perm[i];
		perm[i] = perm[j];
		perm[j] = t;
	end
endtask

task automatic pick_skews(input int base);
	int s;
	max_delay = 0;
	for (int l = 0; l < NUM_LANES; l++) begin
		draw_upto(MAX_SKEW_BLOCK_N - 2, s);
		delay[l] = base + s;
		if (delay[l] > max_delay)
			max_delay = delay[l];
	end
	$display("skews %0d %0d %0d %0d, physical lanes %0d %0d %0d %0d",
		delay[0] - base, delay[1] - base, delay[2] - base, delay[3] - base,
		perm[0], perm[1], perm[2], perm[3]);
endtask

task automatic report_test(input string name, input int errs);
	if (errs == 0) begin
		test_pass++;
		$display("test %s passed", name);
	end else begin
		test_fail++;
		$display("test %s failed with %0d errors", name, errs);
	end
endtask

// all lanes locked before the deadline, aligned_o low meanwhile
task automatic wait_lock_all(input string name, input int deadline);
	int errs;
	errs = 0;
	@(negedge clk);
	while (lane_lock !== '1 && cycle_cnt < deadline) begin
		if (aligned !== 1'b0) begin
			$display("** Error at %0t: aligned_o high before all lanes locked", $time);
			errs++;
		end
		@(negedge clk);
	end
	if (lane_lock !== '1) begin
		$display("lanes did not all lock by cycle %0d", deadline);
		errs++;
	end
	report_test(name, errs);
endtask

task automatic expect_align(input string name, input int deadline);
	int errs;
	errs = 0;
	while (aligned !== 1'b1 && cycle_cnt < deadline)
		@(negedge clk);
	if (aligned !== 1'b1) begin
		$display("aligned_o did not rise by cycle %0d", deadline);
		errs++;
	end
	report_test(name, errs);
endtask

task automatic check_window(input string suffix, input int cycles);
	@(posedge clk);
	deskew_err = 0;
	reorder_err = 0;
	am_rows = 0;
	have_prev = 0;
	cmp_en = 1;
	repeat (cycles) @(posedge clk);
	cmp_en = 0;
	if (am_rows != cycles / AM_PERIOD) begin
		$display("** Error at %0t: %0d marker rows, expected %0d", $time, am_rows,
			cycles / AM_PERIOD);
		deskew_err++;
	end
	report_test({"deskew", suffix}, deskew_err);
	report_test({"reorder", suffix}, reorder_err);
endtask

// streams into the delay lines, taps onto the swapped physical lanes
always @(posedge clk) begin : drive_lanes
	logic [65:0] blk;
	#DRV_DLY;
	drv_idx++;
	for (int l = 0; l < NUM_LANES; l++) begin
		for (int i = DLY_N - 1; i > 0; i--) begin
			dline[l][i] = dline[l][i-1];
		end
		blk = block_at(l, drv_idx);
		if (corrupt_pending && l == CORRUPT_LANE && drv_idx % AM_PERIOD == 0) begin
			blk[63:56] = ~blk[63:56]; // m0 no longer matches m4
			corrupt_pending = 0;
		end
		dline[l][0] = blk;
		lane_data[perm[l]] = dline[l][delay[l]];
	end
end

// output compare, every lane lands with the same total delay
always @(negedge clk) begin : compare_out
	longint      idx;
	longint      seq0;
	logic [65:0] exp;
	bit          row_am;
	if (cmp_en) begin
		idx = drv_idx - LAT - max_delay;
		row_am = (data_out[0][65:64] == 2'b10);
		seq0 = data_out[0][47:0];
		if (aligned !== 1'b1) begin
			$display("** Error at %0t: aligned_o dropped while lanes are stable", $time);
			deskew_err++;
		end
		for (int k = 0; k < NUM_LANES; k++) begin
			if ((data_out[k][65:64] == 2'b10) != row_am ||
			    (!row_am && data_out[k][47:0] != seq0[47:0])) begin
				$display("** Error at %0t: lane %0d out of step with lane 0", $time, k);
				deskew_err++;
			end
			exp = block_at(k, idx);
			if (data_out[k] !== exp) begin
				$display("** Error at %0t: lane %0d got %h, expected %h", $time, k,
					data_out[k], exp);
				reorder_err++;
			end
		end
		if (row_am) begin
			am_rows++;
		end else begin
			if (have_prev && seq0 != prev_seq + 1) begin
				$display("** Error at %0t: sequence %0d follows %0d", $time, seq0, prev_seq);
				deskew_err++;
			end
			prev_seq = seq0;
			have_prev = 1;
		end
	end
end

always @(posedge clk) begin
	cycle_cnt++;
	if (cycle_cnt >= TIMEOUT_CYC) begin
		$display("run stopped at the limit of %0d cycles", TIMEOUT_CYC);
		$display("Something failed");
		$finish;
	end
end

initial begin : main_seq
	int t0;
	lane_data = '0;
	lfsr_q = SEED;
	for (int l = 0; l < NUM_LANES; l++) begin
		for (int i = 0; i < DLY_N; i++) begin
			dline[l][i] = '0;
		end
	end
	pick_perm();
	pick_skews(0);

	wait (nreset === 1'b1);
	t0 = cycle_cnt;
	wait_lock_all("lock", t0 + 3 * AM_PERIOD);
	expect_align("align", t0 + 5 * AM_PERIOD);
	check_window("", 2 * AM_PERIOD);

	// one bad marker on one lane
	@(negedge clk);
	corrupt_pending = 1;
	t0 = cycle_cnt;
	while (aligned === 1'b1 && cycle_cnt < t0 + 2 * AM_PERIOD)
		@(negedge clk);
	if (aligned === 1'b1) begin
		$display("aligned_o stayed high after the corrupted marker");
		report_test("loss", 1);
	end else begin
		report_test("loss", 0);
	end

	// later taps on every lane so all of them restart the search together
	repeat (20) @(negedge clk);
	pick_skews(RELOCK_BASE);
	t0 = cycle_cnt;
	wait_lock_all("relock", t0 + 3 * AM_PERIOD);
	expect_align("realign", t0 + 5 * AM_PERIOD);
	check_window(" after relock", 2 * AM_PERIOD);

	$display("%0d tests passed, %0d tests failed", test_pass, test_fail);
	if (test_fail == 0)
		$display("Everything OK");
	else
		$display("Something failed");
	$finish;
end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Testbench clock and reset
// free running clock, active-low reset held for a number of rising edges
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD    = 100,
	parameter int RESET_CYC = 10,
	parameter int DRV_DLY   = 10
)(
	output logic clk_o,
	output logic nreset_o
);

initial begin
	clk_o = 1'b0;
	forever #(PERIOD / 2) clk_o = ~clk_o;
end

initial begin
	nreset_o = 1'b0;
	repeat (RESET_CYC) @(posedge clk_o);
	#DRV_DLY;
	nreset_o = 1'b1; // released just after an edge like all other inputs
end

endmodule

`default_nettype wire

// ==== pcs_rx_deskew.sv ====
// Multi-lane PCS receive deskew
// per-lane marker lock and deskew buffer, a shared lane controller
// and a final reorder into logical lane order
`default_nettype none

module pcs_rx_deskew #(
	parameter int NUM_LANES        = 4,
	parameter int AM_PERIOD        = 64, // 16384 on real links
	parameter int MAX_SKEW_BLOCK_N = 8
)(
	input  wire                                             clk,
	input  wire                                             nreset,

	input  wire [NUM_LANES-1:0][pcs_rx_pkg::BLOCK_W-1:0]    lane_data_i,

	output wire [NUM_LANES-1:0][pcs_rx_pkg::BLOCK_W-1:0]    data_o,
	output wire                                             aligned_o,
	output wire [NUM_LANES-1:0]                             lane_lock_o
);
import pcs_rx_pkg::*;

wire [NUM_LANES-1:0][BLOCK_W-1:0]   lock_data;   // after marker lock stage
wire [NUM_LANES-1:0][BLOCK_W-1:0]   deskew_data; // after deskew buffers
wire [NUM_LANES-1:0]                am_v;
wire [NUM_LANES-1:0]                lock_lost;
wire [NUM_LANES-1:0][LANE_ID_W-1:0] lane_id;
wire                                lock_full;

for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
	am_lock_lane_rx #(
		.AM_PERIOD(AM_PERIOD)
	) am_lock_i (
		.clk           (clk),
		.nreset        (nreset),
		.data_i        (lane_data_i[l]),
		.data_o        (lock_data[l]),
		.am_v_o        (am_v[l]),
		.lock_o        (lane_lock_o[l]),
		.lock_lost_v_o (lock_lost[l]),
		.lane_id_o     (lane_id[l])
	);

	deskew_lane_rx #(
		.MAX_SKEW_BLOCK_N(MAX_SKEW_BLOCK_N)
	) deskew_i (
		.clk         (clk),
		.nreset      (nreset),
		.am_v_i      (am_v[l]),
		.lock_full_i (lock_full),
		.data_i      (lock_data[l]),
		.data_o      (deskew_data[l])
	);
end

deskew_ctrl_rx #(
	.NUM_LANES(NUM_LANES)
) ctrl_i (
	.clk           (clk),
	.nreset        (nreset),
	.am_v_i        (am_v),
	.lock_i        (lane_lock_o),
	.lock_lost_v_i (lock_lost),
	.lock_full_o   (lock_full)
);

lane_reorder_rx #(
	.NUM_LANES(NUM_LANES)
) reorder_i (
	.clk         (clk),
	.nreset      (nreset),
	.lane_id_i   (lane_id),
	.lock_full_i (lock_full),
	.data_i      (deskew_data),
	.data_o      (data_o),
	.aligned_o   (aligned_o)
);

endmodule

`default_nettype wire

// ==== lane_reorder_rx.sv ====
// Lane reorder
// registered crossbar putting each physical lane on the output lane
// named by its captured marker lane number
`default_nettype none

module lane_reorder_rx #(
	parameter int NUM_LANES = 4
)(
	input  wire                                               clk,
	input  wire                                               nreset,

	input  wire  [NUM_LANES-1:0][pcs_rx_pkg::LANE_ID_W-1:0]   lane_id_i,
	input  wire                                               lock_full_i,
	input  wire  [NUM_LANES-1:0][pcs_rx_pkg::BLOCK_W-1:0]     data_i,

	output logic [NUM_LANES-1:0][pcs_rx_pkg::BLOCK_W-1:0]     data_o, // logical order
	output logic                                              aligned_o
);
import pcs_rx_pkg::*;

logic [NUM_LANES-1:0][BLOCK_W-1:0] xbar;
logic [NUM_LANES-1:0][BLOCK_W-1:0] data_q;
logic                              aligned_q;

// for logical lane k pick the physical lane carrying lane number k
always_comb begin
	for (int k = 0; k < NUM_LANES; k++) begin
		xbar[k] = data_i[k]; // straight through when no lane claims k
		for (int p = 0; p < NUM_LANES; p++) begin
			if (lane_id_i[p] == LANE_ID_W'(k)) begin
				xbar[k] = data_i[p];
			end
		end
	end
end

always_ff @(posedge clk) begin
	data_q <= xbar;
end

// aligned follows lock_full through the same register stage as the data
always_ff @(posedge clk) begin
	if (!nreset) begin
		aligned_q <= 1'b0;
	end else begin
		aligned_q <= lock_full_i;
	end
end

assign data_o = data_q;
assign aligned_o = aligned_q;

endmodule

`default_nettype wire

// ==== deskew_lane_rx.sv ====
// Deskew buffer for one lane
// counts blocks since this lane's marker until all lanes have reported,
// then reads a shift buffer at that count to line up with the slowest lane
`default_nettype none

module deskew_lane_rx #(
	parameter int MAX_SKEW_BLOCK_N = 8
)(
	input  wire                             clk,
	input  wire                             nreset,

	input  wire                             am_v_i,
	input  wire                             lock_full_i,
	input  wire  [pcs_rx_pkg::BLOCK_W-1:0]  data_i,

	output logic [pcs_rx_pkg::BLOCK_W-1:0]  data_o // input delayed by skew+1
);
import pcs_rx_pkg::*;

localparam int SKEW_CNT_W = (MAX_SKEW_BLOCK_N > 1) ? $clog2(MAX_SKEW_BLOCK_N) : 1;

logic [SKEW_CNT_W-1:0] skew_q;
logic [SKEW_CNT_W-1:0] skew_next;
logic                  skew_en;
logic [BLOCK_W-1:0]    buff_q [MAX_SKEW_BLOCK_N];
logic [BLOCK_W-1:0]    buff_rd;

// the marker loads -1, lock_full lands two cycles after the last
// lane's marker so that lane settles at 0 and earlier lanes at their lead
assign skew_next = am_v_i ? '1 : skew_q + 1'b1;
assign skew_en = ~lock_full_i; // frozen once all lanes are in

always_ff @(posedge clk) begin
	if (!nreset) begin
		skew_q <= '0;
	end else if (skew_en) begin
		skew_q <= skew_next;
	end
end

// shift buffer, entry 0 is the newest block
always_ff @(posedge clk) begin
	buff_q[0] <= data_i;
	for (int i = 1; i < MAX_SKEW_BLOCK_N; i++) begin
		buff_q[i] <= buff_q[i-1];
	end
end

// read pointer is the skew count
always_comb begin
	buff_rd = buff_q[0];
	for (int i = 0; i < MAX_SKEW_BLOCK_N; i++) begin
		if (skew_q == SKEW_CNT_W'(i)) begin
			buff_rd = buff_q[i];
		end
	end
end

assign data_o = buff_rd;

endmodule

`default_nettype wire

// ==== deskew_ctrl_rx.sv ====
// Deskew lane controller
// collects one marker per locked lane and raises lock_full once all
// lanes have reported, any lock loss starts the gathering over
`default_nettype none

module deskew_ctrl_rx #(
	parameter int NUM_LANES = 4
)(
	input  wire                  clk,
	input  wire                  nreset,

	input  wire [NUM_LANES-1:0]  am_v_i,
	input  wire [NUM_LANES-1:0]  lock_i,
	input  wire [NUM_LANES-1:0]  lock_lost_v_i,

	output logic                 lock_full_o // every lane has seen its marker
);

logic [NUM_LANES-1:0] seen_q;
logic                 all_lock_q;
logic                 lock_full_q;
logic                 all_lock;
logic                 any_lost;

assign all_lock = &lock_i;
assign any_lost = |lock_lost_v_i;

always_ff @(posedge clk) begin
	if (!nreset) begin
		seen_q      <= '0;
		all_lock_q  <= 1'b0;
		lock_full_q <= 1'b0;
	end else begin
		all_lock_q <= all_lock;
		if (any_lost) begin
			seen_q      <= '0;
			lock_full_q <= 1'b0;
		end else begin
			// the marker that completes a lane's lock is not counted,
			// gathering starts with the next full round of markers
			if (all_lock && all_lock_q) begin
				seen_q <= seen_q | am_v_i;
			end
			lock_full_q <= lock_full_q | (&seen_q); // sticky until a loss
		end
	end
end

assign lock_full_o = lock_full_q;

endmodule

`default_nettype wire

// ==== am_lock_lane_rx.sv ====
// Alignment marker lock for one physical lane
// finds markers from the table, verifies one period later and locks,
// then keeps the captured logical lane number while markers keep coming
`default_nettype none

module am_lock_lane_rx #(
	parameter int AM_PERIOD = 64
)(
	input  wire                               clk,
	input  wire                               nreset,

	input  wire  [pcs_rx_pkg::BLOCK_W-1:0]    data_i,

	output logic [pcs_rx_pkg::BLOCK_W-1:0]    data_o,
	output logic                              am_v_o, // marker on data_o this cycle
	output logic                              lock_o,
	output logic                              lock_lost_v_o,
	output logic [pcs_rx_pkg::LANE_ID_W-1:0]  lane_id_o
);
import pcs_rx_pkg::*;

localparam int CNT_W = (AM_PERIOD > 1) ? $clog2(AM_PERIOD) : 1;
localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(AM_PERIOD - 1);
localparam logic [CNT_W-1:0] CNT_FIRST = CNT_W'(1); // block right after a marker

localparam logic [1:0] ST_SEARCH = 2'd0;
localparam logic [1:0] ST_VERIFY = 2'd1;
localparam logic [1:0] ST_LOCKED = 2'd2;

am_payload_u           payload;
logic [AM_MARK_W-1:0]  marker;
logic                  am_match;
logic [LANE_ID_W-1:0]  match_id;
logic                  at_exp;
logic [CNT_W-1:0]      cnt_q;
logic [CNT_W-1:0]      cnt_next;
logic [1:0]            state_q;
logic [LANE_ID_W-1:0]  id_q;
logic                  am_v_q;
logic                  lost_q;
logic [BLOCK_W-1:0]    data_q;

// match the incoming block against every table entry
always_comb begin
	payload.raw = data_i[PAYLOAD_W-1:0];
	marker = '0;
	am_match = 1'b0;
	match_id = '0;
	for (int l = 0; l < AM_LANE_N; l++) begin
		marker = am_marker_table(l[LANE_ID_W-1:0]);
		if (data_i[BLOCK_W-1:PAYLOAD_W] == AM_SYNC &&
		    {payload.am.m0, payload.am.m1, payload.am.m2} == marker &&
		    {payload.am.m4, payload.am.m5, payload.am.m6} == ~marker) begin
			am_match = 1'b1;
			match_id = l[LANE_ID_W-1:0];
		end
	end
end

// block position within the marker period
assign cnt_next = (cnt_q == CNT_LAST) ? '0 : cnt_q + 1'b1;
assign at_exp = (cnt_q == '0);

always_ff @(posedge clk) begin
	if (!nreset) begin
		state_q <= ST_SEARCH;
		cnt_q   <= '0;
		id_q    <= '0;
		am_v_q  <= 1'b0;
		lost_q  <= 1'b0;
	end else begin
		am_v_q <= 1'b0;
		lost_q <= 1'b0;
		cnt_q  <= cnt_next;
		case (state_q)
			ST_SEARCH: begin
				if (am_match) begin
					state_q <= ST_VERIFY;
					id_q    <= match_id;
					cnt_q   <= CNT_FIRST;
					am_v_q  <= 1'b1;
				end
			end
			ST_VERIFY: begin
				if (am_match && at_exp && match_id == id_q) begin
					state_q <= ST_LOCKED; // second marker, one period on
					am_v_q  <= 1'b1;
				end else if (am_match) begin
					id_q   <= match_id; // restart from this marker
					cnt_q  <= CNT_FIRST;
					am_v_q <= 1'b1;
				end else if (at_exp) begin
					state_q <= ST_SEARCH;
				end
			end
			ST_LOCKED: begin
				if (at_exp) begin
					if (am_match && match_id == id_q) begin
						am_v_q <= 1'b1;
					end else begin
						state_q <= ST_SEARCH;
						lost_q  <= 1'b1;
					end
				end
			end
			default: state_q <= ST_SEARCH;
		endcase
	end
end

// payload pipe
always_ff @(posedge clk) begin
	data_q <= data_i;
end

assign data_o = data_q;
assign am_v_o = am_v_q;
assign lock_o = (state_q == ST_LOCKED);
assign lock_lost_v_o = lost_q;
assign lane_id_o = id_q;

endmodule

`default_nettype wire

// ==== pcs_rx_pkg.sv ====
// PCS receive deskew shared definitions
// block widths, alignment marker field view and the per-lane marker table
`default_nettype none

package pcs_rx_pkg;

	localparam int BLOCK_W   = 66; // 2-bit sync header + 64-bit payload
	localparam int PAYLOAD_W = 64;
	localparam int LANE_ID_W = 2;
	localparam int AM_LANE_N = 1 << LANE_ID_W; // entries in the marker table
	localparam int AM_MARK_W = 24; // m0..m2

	// control block sync header
	localparam logic [1:0] AM_SYNC = 2'b10;

	// alignment marker payload, m0 in the top byte
	typedef struct packed {
		logic [7:0] m0;
		logic [7:0] m1;
		logic [7:0] m2;
		logic [7:0] bip3;
		logic [7:0] m4;
		logic [7:0] m5;
		logic [7:0] m6;
		logic [7:0] bip7;
	} am_fields_s;

	// one payload word, seen either raw or as marker fields
	typedef union packed {
		logic [PAYLOAD_W-1:0] raw;
		am_fields_s           am;
	} am_payload_u;

	// {m0, m1, m2} for a logical lane, m4..m6 are their complements
	function automatic logic [AM_MARK_W-1:0] am_marker_table(
		input logic [LANE_ID_W-1:0] lane
	);
		case (lane)
			2'd0:    return 24'h907647;
			2'd1:    return 24'hF0C4E6;
			2'd2:    return 24'hC5659B;
			default: return 24'hA2793D;
		endcase
	endfunction

endpackage

`default_nettype wire
